// File: source/axi_rd_pkg.sv
/*
  Shared widths, depths and types for the AXI4 read slave.
  One data width only; sizes above MAX_SIZE answer with SLVERR.
  WRAP and the reserved burst code are treated as INCR.
*/
package axi_rd_pkg;

    // ------------------------------------------------
    // Bus widths
    // ------------------------------------------------
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int ID_W    = 4;
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    // Bytes per data word, and the widest legal size code
    localparam int BUS_BYTES = DATA_W / 8;
    localparam int MAX_SIZE  = $clog2(BUS_BYTES);

    // An INCR burst must stay below this bit
    localparam int PAGE_BIT = 12;

    // ------------------------------------------------
    // Buffering and memory timing
    // ------------------------------------------------
    localparam int REQ_DEPTH = 4;
    localparam int RSP_DEPTH = 8;
    localparam int RD_LAT    = 2;

    // Counter widths for response occupancy and beats in flight
    localparam int RSP_CNT_W = $clog2(RSP_DEPTH + 1);
    localparam int INF_W     = $clog2(RD_LAT + 1);

    // Burst and response codes
    localparam logic [BURST_W-1:0] BT_FIXED    = 2'd0;
    localparam logic [BURST_W-1:0] BT_INCR     = 2'd1;
    localparam logic [RESP_W-1:0]  RESP_OKAY   = 2'd0;
    localparam logic [RESP_W-1:0]  RESP_SLVERR = 2'd2;

    // ------------------------------------------------
    // Channel payloads
    // ------------------------------------------------
    // AR payload, also the request FIFO entry
    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [ADDR_W-1:0]  addr;
        logic [LEN_W-1:0]   len;
        logic [SIZE_W-1:0]  size;
        logic [BURST_W-1:0] burst;
    } ar_req_t;

    // R payload, also the response FIFO entry
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [RESP_W-1:0] resp;
        logic              last;
    } r_beat_t;

    // Per-beat tag carried beside the memory latency
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [RESP_W-1:0] resp;
        logic              last;
    } beat_info_t;

    typedef enum logic [1:0] {IDLE, FIRST, BURST} burst_phase_t;

endpackage

// File: source/sync_fifo.sv
/*
  Single-clock FIFO with any packed payload type.
  Push when full and pop when empty are dropped.
  Head is combinational from the storage array.
*/
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  T                             din,
    input  logic                         pop,
    output T                             dout,
    output logic                         full,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    T                            mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]    wr_ptr;
    logic [$clog2(DEPTH)-1:0]    rd_ptr;
    logic                        do_push;
    logic                        do_pop;

    // Qualified handshakes
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == DEPTH);
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];

    // Storage, written only on an accepted push
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    // ------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Explicit wrap so any depth works
            if (do_push)
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/burst_addr_gen.sv
/*
  Turns the request at the FIFO head into one memory read per beat.
  WRAP is stepped like INCR; INCR holds its address at a 4 KB page edge.
  A beat is issued only while room is high.
*/
`timescale 1ns/1ps

module burst_addr_gen import axi_rd_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  ar_req_t           head,
    input  logic              empty,
    input  logic              room,
    output logic              pop,
    output logic              issue,
    output logic [ADDR_W-1:0] addr,
    output beat_info_t        info
);

    burst_phase_t      phase;
    burst_phase_t      phase_nxt;
    ar_req_t           req_q;
    ar_req_t           cur_req;
    logic [LEN_W-1:0]  beat_cnt;
    logic [ADDR_W-1:0] burst_addr;
    logic [ADDR_W-1:0] size_mask;
    logic [ADDR_W-1:0] aligned;
    logic [ADDR_W-1:0] step;
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] stepped;
    logic [ADDR_W-1:0] next_addr;
    logic              last;

    // Head drives beat 0, the latched copy drives the rest
    assign cur_req = (phase == FIRST) ? head : req_q;

    // Beat 0 and the FIFO pop go together
    assign pop   = (phase == FIRST) && !empty && room;
    assign issue = pop || ((phase == BURST) && room);
    assign last  = (phase == FIRST) ? (head.len == '0) : (beat_cnt == req_q.len);

    // First beat keeps the unaligned master address
    assign addr = (phase == FIRST) ? head.addr : burst_addr;

    // ------------------------------------------------
    // Address stepping
    // ------------------------------------------------
    always_comb begin
        size_mask = {ADDR_W{1'b1}} << cur_req.size;
        aligned   = cur_req.addr & size_mask;
        // FIXED repeats the aligned address
        step      = (cur_req.burst == BT_FIXED) ? '0 : (ADDR_W'(1) << cur_req.size);
        base      = (phase == FIRST) ? aligned : burst_addr;
        stepped   = base + step;
        // Hold when the step would leave the start page
        if (stepped[ADDR_W-1:PAGE_BIT] == aligned[ADDR_W-1:PAGE_BIT])
            next_addr = stepped;
        else
            next_addr = base;
    end

    // Beat tag for the delay line
    always_comb begin
        info.id   = cur_req.id;
        info.resp = (cur_req.size > MAX_SIZE) ? RESP_SLVERR : RESP_OKAY;
        info.last = last;
    end

    // ------------------------------------------------
    // Burst phase FSM
    // ------------------------------------------------
    always_comb begin
        phase_nxt = phase;
        case (phase)
            IDLE:    phase_nxt = FIRST;
            FIRST: begin
                // Single-beat bursts stay here
                if (pop && (head.len != '0))
                    phase_nxt = BURST;
            end
            BURST: begin
                if (issue && last)
                    phase_nxt = FIRST;
            end
            default: phase_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= IDLE;
            beat_cnt   <= '0;
            burst_addr <= '0;
        end else begin
            phase <= phase_nxt;
            if (issue) begin
                // Beat 0 done on pop, count restarts at 1
                beat_cnt   <= pop ? LEN_W'(1) : beat_cnt + 1'b1;
                burst_addr <= next_addr;
            end
        end
    end

    // Request copy for the remaining beats
    always_ff @(posedge clk) begin
        if (pop)
            req_q <= head;
    end

endmodule

// File: source/rd_wait_pipe.sv
/*
  Delays each beat tag by RD_LAT cycles to line up with mem_rdata.
  RD_LAT must be at least 1.
*/
`timescale 1ns/1ps

module rd_wait_pipe import axi_rd_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             issue,
    input  beat_info_t       info,
    output logic             push,
    output beat_info_t       info_out,
    output logic [INF_W-1:0] in_flight
);

    logic [RD_LAT-1:0] valid_q;
    beat_info_t        info_q [RD_LAT];

    // Last stage meets the memory data
    assign push     = valid_q[RD_LAT-1];
    assign info_out = info_q[RD_LAT-1];

    // ------------------------------------------------
    // Valid bits, one per stage
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= issue;
            for (int i = 1; i < RD_LAT; i++)
                valid_q[i] <= valid_q[i-1];
        end
    end

    // Tags shift in step with the valid bits
    always_ff @(posedge clk) begin
        info_q[0] <= info;
        for (int i = 1; i < RD_LAT; i++)
            info_q[i] <= info_q[i-1];
    end

    // Beats issued but not yet in the response FIFO
    always_comb begin
        in_flight = '0;
        for (int i = 0; i < RD_LAT; i++)
            in_flight = in_flight + INF_W'(valid_q[i]);
    end

endmodule

// File: source/axi_rd_slave.sv
/*
  AXI4 read slave over a fixed-latency memory port, one clock.
  r_valid follows an accepted AR by at least 2 + RD_LAT cycles.
  Response room is reserved before issue, so r_ready stalls lose nothing.
*/
`timescale 1ns/1ps

module axi_rd_slave import axi_rd_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  ar_req_t           ar,
    input  logic              ar_valid,
    output logic              ar_ready,
    output r_beat_t           r,
    output logic              r_valid,
    input  logic              r_ready,
    output logic              mem_re,
    output logic [ADDR_W-1:0] mem_addr,
    input  logic [DATA_W-1:0] mem_rdata
);

    ar_req_t              req_head;
    logic                 req_full;
    logic                 req_empty;
    logic                 req_pop;
    logic                 issue;
    logic                 room;
    beat_info_t           beat_info;
    beat_info_t           beat_dly;
    logic                 rsp_push;
    r_beat_t              rsp_din;
    logic                 rsp_empty;
    logic [RSP_CNT_W-1:0] rsp_count;
    logic [INF_W-1:0]     in_flight;
    logic [RSP_CNT_W:0]   credit_used;

    // ------------------------------------------------
    // AR side
    // ------------------------------------------------
    assign ar_ready = !req_full;

    sync_fifo #(.T(ar_req_t), .DEPTH(REQ_DEPTH)) u_req_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(ar_valid && ar_ready), .din(ar),
        .pop(req_pop), .dout(req_head),
        .full(req_full), .empty(req_empty), .count()
    );

    // Beats queued plus beats still in the memory pipe
    assign credit_used = rsp_count + in_flight;
    assign room        = (credit_used < RSP_DEPTH);

    burst_addr_gen u_burst_gen (
        .clk(clk), .rst_n(rst_n),
        .head(req_head), .empty(req_empty), .room(room),
        .pop(req_pop), .issue(issue), .addr(mem_addr), .info(beat_info)
    );

    assign mem_re = issue;

    rd_wait_pipe u_wait_pipe (
        .clk(clk), .rst_n(rst_n),
        .issue(issue), .info(beat_info),
        .push(rsp_push), .info_out(beat_dly), .in_flight(in_flight)
    );

    // ------------------------------------------------
    // R side
    // ------------------------------------------------
    // Delayed tag meets the returned word
    always_comb begin
        rsp_din.id   = beat_dly.id;
        rsp_din.data = mem_rdata;
        rsp_din.resp = beat_dly.resp;
        rsp_din.last = beat_dly.last;
    end

    sync_fifo #(.T(r_beat_t), .DEPTH(RSP_DEPTH)) u_rsp_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(rsp_push), .din(rsp_din),
        .pop(r_valid && r_ready), .dout(r),
        .full(), .empty(rsp_empty), .count(rsp_count)
    );

    assign r_valid = !rsp_empty;

endmodule

// File: sim/axi_rd_slave_assert.sv
/*
  Protocol checks bound into every axi_rd_slave instance.
  fail_cnt counts assertion failures for the closing summary.
*/
`timescale 1ns/1ps

module axi_rd_slave_assert import axi_rd_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 ar_valid,
    input logic                 ar_ready,
    input r_beat_t              r,
    input logic                 r_valid,
    input logic                 r_ready,
    input logic                 mem_re,
    input logic                 rsp_push,
    input logic [RSP_CNT_W-1:0] rsp_count,
    input logic                 req_pop
);

    int fail_cnt = 0;

    // Accepted AR requests not yet taken by the burst generator
    int req_pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            req_pending <= 0;
        else
            req_pending <= req_pending + int'(ar_valid && ar_ready) - int'(req_pop);
    end

    // --------------------------------------------------
    // R channel holds its beat until r_ready
    // --------------------------------------------------
    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (r_valid && !r_ready) |=> (r_valid && $stable(r)))
    else begin
        fail_cnt++;
        $error("R beat changed or dropped while r_ready was low");
    end

    // Response credit keeps the FIFO from overflowing
    rsp_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_push |-> (rsp_count < RSP_DEPTH))
    else begin
        fail_cnt++;
        $error("Response FIFO pushed while full");
    end

    req_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        req_pop |-> (req_pending > 0))
    else begin
        fail_cnt++;
        $error("Request FIFO popped while empty");
    end

    // Idle outputs in reset and on the first cycle out of it
    reset_outputs: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (ar_ready && !r_valid && !mem_re))
    else begin
        fail_cnt++;
        $error("ar_ready, r_valid or mem_re wrong around reset");
    end

endmodule

bind axi_rd_slave axi_rd_slave_assert u_assert (
    .clk(clk), .rst_n(rst_n), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .r(r), .r_valid(r_valid), .r_ready(r_ready), .mem_re(mem_re),
    .rsp_push(rsp_push), .rsp_count(rsp_count),
    .req_pop(req_pop)
);

// File: sim/tb_axi_rd_slave.sv
/*
  Testbench for the AXI4 read slave over a fixed-latency memory model.
  Memory word is the address XOR 32'hA5A5_0000, returned RD_LAT cycles late.
  Inputs change on the falling edge, R beats are checked on the rising edge.
*/
`timescale 1ns/1ps

module tb_axi_rd_slave import axi_rd_pkg::*;;

    logic              clk = 1'b0;
    logic              rst_n;
    ar_req_t           ar;
    logic              ar_valid;
    logic              ar_ready;
    r_beat_t           r;
    logic              r_valid;
    logic              r_ready;
    logic              mem_re;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_rdata;
    logic [ADDR_W-1:0] mem_pipe [RD_LAT];

    // Scoreboard state
    r_beat_t           exp_q [$];
    r_beat_t           exp_beat;
    int                errors;
    int                timeouts;
    string             test_name;
    logic              throttle;
    logic [31:0]       rng;
    logic [31:0]       rdy_rng;

    axi_rd_slave dut0 (
        .clk(clk), .rst_n(rst_n),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready),
        .mem_re(mem_re), .mem_addr(mem_addr), .mem_rdata(mem_rdata)
    );

    always #2 clk = ~clk;

    // --------------------------------------------------
    // Memory model as a delay line on read addresses
    // --------------------------------------------------
    always @(posedge clk) begin
        // Only a read cycle carries an address, idle slots return unknown data
        mem_pipe[0] <= mem_re ? mem_addr : 'x;
        for (int i = 1; i < RD_LAT; i++)
            mem_pipe[i] <= mem_pipe[i-1];
    end

    assign mem_rdata = mem_pipe[RD_LAT-1] ^ 32'hA5A5_0000;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected beat address with the page hold applied
    function automatic logic [ADDR_W-1:0] beat_addr(input ar_req_t req, input int beat);
        logic [ADDR_W-1:0] aligned;
        logic [ADDR_W-1:0] step;
        logic [ADDR_W-1:0] a;
        aligned = (req.addr >> req.size) << req.size;
        step    = (req.burst == BT_FIXED) ? 32'd0 : (32'd1 << req.size);
        a       = aligned;
        if (beat == 0)
            return req.addr;
        for (int i = 1; i <= beat; i++) begin
            if (((a + step) >> PAGE_BIT) == (aligned >> PAGE_BIT))
                a = a + step;
        end
        return a;
    endfunction

    function automatic ar_req_t make_req(input logic [ID_W-1:0] id,
                                         input logic [ADDR_W-1:0] addr,
                                         input logic [LEN_W-1:0] len,
                                         input logic [SIZE_W-1:0] size,
                                         input logic [BURST_W-1:0] burst);
        ar_req_t req;
        req.id    = id;
        req.addr  = addr;
        req.len   = len;
        req.size  = size;
        req.burst = burst;
        return req;
    endfunction

    task automatic check_value(input string field, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
        assert (act === exp)
        else begin
            errors++;
            $display("Error %s %s: expected %h actual %h", test_name, field, exp, act);
        end
    endtask

    // --------------------------------------------------
    // AR driver that queues the expected beats up front
    // --------------------------------------------------
    task automatic send_ar(input ar_req_t req);
        r_beat_t beat;
        int      cycles;
        if (timeouts != 0)
            return;
        @(negedge clk);
        ar       = req;
        ar_valid = 1'b1;
        for (int b = 0; b <= req.len; b++) begin
            beat.id   = req.id;
            beat.data = beat_addr(req, b) ^ 32'hA5A5_0000;
            // Wider than the data bus gives SLVERR
            beat.resp = ((32'd1 << req.size) > BUS_BYTES) ? RESP_SLVERR : RESP_OKAY;
            beat.last = (b == req.len);
            exp_q.push_back(beat);
        end
        cycles = 0;
        while (!ar_ready && cycles < 1000) begin
            @(negedge clk);
            cycles++;
        end
        if (!ar_ready) begin
            timeouts++;
            ar_valid = 1'b0;
            $display("Timeout in test %s: AR request was never accepted", test_name);
        end else begin
            @(posedge clk);
        end
    endtask

    task automatic ar_idle();
        @(negedge clk);
        ar_valid = 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        if (timeouts != 0)
            return;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 4000) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("Timeout in test %s: %0d read beats never came back", test_name,
                     exp_q.size());
        end
    endtask

    // R ready with random gaps when throttled
    always @(negedge clk) begin
        rdy_rng = xorshift(rdy_rng);
        r_ready = throttle ? rdy_rng[0] : 1'b1;
    end

    // --------------------------------------------------
    // R monitor and scoreboard
    // --------------------------------------------------
    always @(posedge clk) begin
        if (rst_n && r_valid && r_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Test %s: R beat arrived with no read outstanding", test_name);
            end else begin
                exp_beat = exp_q.pop_front();
                check_value("id", DATA_W'(exp_beat.id), DATA_W'(r.id));
                check_value("data", exp_beat.data, r.data);
                check_value("resp", DATA_W'(exp_beat.resp), DATA_W'(r.resp));
                check_value("last", DATA_W'(exp_beat.last), DATA_W'(r.last));
            end
        end
    end

    initial begin
        ar_req_t req;
        rst_n     = 1'b0;
        ar        = '0;
        ar_valid  = 1'b0;
        r_ready   = 1'b0;
        throttle  = 1'b0;
        errors    = 0;
        timeouts  = 0;
        test_name = "reset";
        rng       = 32'h68a1;
        rdy_rng   = 32'h68a1;
        for (int i = 0; i < RD_LAT; i++)
            mem_pipe[i] = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        test_name = "single_incr";
        send_ar(make_req(4'h3, 32'h0000_0104, 8'd0, 3'd2, BT_INCR));
        ar_idle();
        wait_done();

        // Starts mid-word, then steps from the aligned address
        test_name = "unaligned_incr";
        send_ar(make_req(4'h5, 32'h0000_0203, 8'd7, 3'd2, BT_INCR));
        ar_idle();
        wait_done();

        test_name = "fixed";
        send_ar(make_req(4'h9, 32'h0000_0300, 8'd3, 3'd2, BT_FIXED));
        ar_idle();
        wait_done();

        // Crosses 0x1000 after two beats, size 3 is too wide
        test_name = "page_edge";
        send_ar(make_req(4'hC, 32'h0000_0FF0, 8'd5, 3'd3, BT_INCR));
        ar_idle();
        wait_done();

        test_name = "random";
        throttle  = 1'b1;
        for (int n = 0; n < 24; n++) begin
            rng = xorshift(rng);
            req = make_req(rng[25:22], {16'h0, rng[15:14], 4'hF, rng[9:0]},
                           {4'h0, rng[19:16]}, {1'b0, rng[27:26]}, rng[21:20]);
            send_ar(req);
        end
        ar_idle();
        wait_done();
        throttle = 1'b0;

        repeat (10) @(negedge clk);
        $display("Check errors: %0d, assertion failures: %0d, timeouts: %0d",
                 errors, dut0.u_assert.fail_cnt, timeouts);
        if (errors == 0 && timeouts == 0 && dut0.u_assert.fail_cnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: axi_rd_slave.f
source/axi_rd_pkg.sv
source/sync_fifo.sv
source/burst_addr_gen.sv
source/rd_wait_pipe.sv
source/axi_rd_slave.sv
sim/axi_rd_slave_assert.sv
sim/tb_axi_rd_slave.sv
